/* verification/chroma_dc_trace.txt */
# qp c0 c1 c2 c3 then levels l0 l1 l2 l3, all decimal, coefs in raster order
# levels come from the 2x2 hadamard output and the forward quantiser with intra rounding
0 10 20 30 40 20 -4 -8 0
0 -5 7 0 -3 0 -2 1 -3
5 100 -50 25 0 8 19 3 14
8 -200 -200 -200 -200 -61 0 0 0
17 300 100 -100 60 10 1 12 10
23 -1000 500 250 -750 -14 -7 0 -35
28 1024 2048 -512 0 20 -12 28 -4
29 3000 -3000 3000 -3000 0 83 0 0
31 4000 4000 4000 4000 91 0 0 0
40 -2048 1024 0 512 -1 -7 -3 -5
45 8000 -4000 2000 1000 8 14 1 12
51 -8000 -8000 -8000 7000 -9 -8 -8 8

/* flist.f */
design/h264_dc_pkg.sv
design/h264dctransform.sv
design/h264_dc_quantise.sv
design/h264_dc_ctrl.sv
design/h264_chroma_dc.sv
verification/h264_chroma_dc_sva.sv
verification/tb_h264_chroma_dc.sv

/* Bender.yml */
package:
  name: h264_chroma_dc

sources:
  - design/h264_dc_pkg.sv
  - design/h264dctransform.sv
  - design/h264_dc_quantise.sv
  - design/h264_dc_ctrl.sv
  - design/h264_chroma_dc.sv
  - target: test
    files:
      - verification/h264_chroma_dc_sva.sv
      - verification/tb_h264_chroma_dc.sv

/* verification/tb_h264_chroma_dc.sv */
// run from the project root so the trace path resolves, QP_DEPTH fixed at 2, trace played twice
`default_nettype none
`timescale 1ns/1ps

module tb_h264_chroma_dc;
        import h264_dc_pkg::*;

        localparam int MAX_BLK = 64;
        localparam int PASSES  = 2;                     // ready held high, then random stalls
        localparam int TIMEOUT = 200;                   // cycles allowed per wait

        logic      CLK2;
        logic      RESET;
        logic      coef_valid;
        dc_coef_t  coef;
        qp_t       qp;
        logic      level_ready;
        logic      coef_ready;
        logic      level_valid;
        dc_level_t level;
        logic      level_comp;
        logic      level_last;

        qp_t       blk_qp   [MAX_BLK];                  // trace contents
        dc_coef_t  blk_coef [MAX_BLK][4];
        dc_level_t blk_lvl  [MAX_BLK][4];
        int        n_blk;
        int        n_checked;                           // levels compared so far
        int        seed_val;
        dc_level_t got_lvl  [$];                        // transfers seen on the level port
        logic      got_comp [$];
        logic      got_last [$];

        h264_chroma_dc #(
                .QP_DEPTH    (2)
        ) i_dut (
                .CLK2        (CLK2),
                .RESET       (RESET),
                .coef_valid  (coef_valid),
                .coef        (coef),
                .qp          (qp),
                .level_ready (level_ready),
                .coef_ready  (coef_ready),
                .level_valid (level_valid),
                .level       (level),
                .level_comp  (level_comp),
                .level_last  (level_last)
        );

        always #10 CLK2 = !CLK2;                        // 20 ns period

        // sampled mid cycle since the transfer happens on the next rising edge
        always @(negedge CLK2) begin
                if (!RESET && level_valid && level_ready) begin
                        got_lvl.push_back(level);
                        got_comp.push_back(level_comp);
                        got_last.push_back(level_last);
                end
        end

        task automatic fail_stop(input string msg);
                $display("%s", msg);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic check_level(input dc_level_t got, input dc_level_t exp, input int blk,
                                   input int pos);
                if (got !== exp)
                        fail_stop($sformatf("Fail at %0t ns: block %0d level %0d is %0d, want %0d",
                                            $time, blk, pos, got, exp));
        endtask

        task automatic check_comp(input logic got, input logic exp, input int blk);
                if (got !== exp)
                        fail_stop($sformatf("Fail at %0t ns: block %0d level_comp is %b, want %b",
                                            $time, blk, got, exp));
        endtask

        task automatic check_last(input logic got, input logic exp, input int blk, input int pos);
                if (got !== exp)
                        fail_stop($sformatf(
                                "Fail at %0t ns: block %0d level %0d level_last %b, want %b",
                                $time, blk, pos, got, exp));
        endtask

        // one block per line and lines starting with # are skipped
        task automatic read_trace();
                int    fd;
                int    n;
                int    q;
                int    c0, c1, c2, c3;
                int    l0, l1, l2, l3;
                string line;
                fd = $fopen("verification/chroma_dc_trace.txt", "r");
                if (fd == 0)
                        fail_stop("cannot open verification/chroma_dc_trace.txt");
                n_blk = 0;
                while (!$feof(fd) && n_blk < MAX_BLK) begin
                        line = "";
                        n = $fgets(line, fd);
                        if (line.len() > 0 && line[0] != "#") begin
                                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                                            q, c0, c1, c2, c3, l0, l1, l2, l3);
                                if (n == 9) begin
                                        blk_qp[n_blk]      = qp_t'(q);
                                        blk_coef[n_blk][0] = dc_coef_t'(c0);
                                        blk_coef[n_blk][1] = dc_coef_t'(c1);
                                        blk_coef[n_blk][2] = dc_coef_t'(c2);
                                        blk_coef[n_blk][3] = dc_coef_t'(c3);
                                        blk_lvl[n_blk][0]  = dc_level_t'(l0);
                                        blk_lvl[n_blk][1]  = dc_level_t'(l1);
                                        blk_lvl[n_blk][2]  = dc_level_t'(l2);
                                        blk_lvl[n_blk][3]  = dc_level_t'(l3);
                                        n_blk++;
                                end
                        end
                end
                $fclose(fd);
        endtask

        // after reset the input is open and the output quiet
        task automatic check_idle();
                repeat (4) begin
                        @(negedge CLK2);
                        if (coef_ready !== 1'b1)
                                fail_stop("coef_ready is not high after reset");
                        if (level_valid !== 1'b0)
                                fail_stop("level_valid went high before any coefficient was sent");
                end
                @(posedge CLK2);
                #2;
        endtask

        task automatic send_coef(input dc_coef_t c, input qp_t q);
                int waited;
                waited     = 0;
                coef_valid = 1'b1;
                coef       = c;
                qp         = q;                         // only used with the 1st coef
                @(negedge CLK2);
                while (coef_ready !== 1'b1) begin
                        waited++;
                        if (waited > TIMEOUT)
                                fail_stop("coef_ready stayed low, input handshake timed out");
                        @(negedge CLK2);
                end
                @(posedge CLK2);                        // accepted on this edge
                #2;
        endtask

        task automatic drive_blocks();
                for (int p = 0; p < PASSES; p++) begin
                        for (int b = 0; b < n_blk; b++) begin
                                for (int k = 0; k < 4; k++)
                                        send_coef(blk_coef[b][k], blk_qp[b]);
                        end
                end
                coef_valid = 1'b0;
        endtask

        // stalls start once the first pass has drained
        task automatic drive_sink();
                while (n_checked < PASSES * n_blk * 4) begin
                        @(posedge CLK2);
                        #2;
                        if (n_checked < n_blk * 4)
                                level_ready = 1'b1;
                        else
                                level_ready = ($urandom % 3) != 0;      // about one stall in three
                end
                level_ready = 1'b1;
        endtask

        task automatic check_blocks();
                int        waited;
                int        blk;
                dc_level_t lv;
                logic      cp;
                logic      ls;
                for (int i = 0; i < PASSES * n_blk * 4; i++) begin
                        waited = 0;
                        while (got_lvl.size() == 0) begin
                                @(posedge CLK2);
                                waited++;
                                if (waited > TIMEOUT)
                                        fail_stop($sformatf("level %0d never arrived", i));
                        end
                        blk = i / 4;                    // counts on across both passes
                        lv  = got_lvl.pop_front();
                        cp  = got_comp.pop_front();
                        ls  = got_last.pop_front();
                        check_level(lv, blk_lvl[blk % n_blk][i % 4], blk, i % 4);
                        check_comp(cp, (blk % 2 == 0) ? COMP_CB : COMP_CR, blk);
                        check_last(ls, (i % 4) == 3, blk, i % 4);
                        n_checked++;
                end
        endtask

        initial begin
                seed_val    = $urandom(43233);
                CLK2        = 1'b0;
                RESET       = 1'b1;
                coef_valid  = 1'b0;
                coef        = '0;
                qp          = '0;
                level_ready = 1'b1;
                n_checked   = 0;
                read_trace();
                if (n_blk == 0)
                        fail_stop("trace file holds no blocks");
                repeat (16) @(posedge CLK2);
                #2;
                RESET = 1'b0;
                check_idle();
                fork
                        drive_blocks();
                        drive_sink();
                        check_blocks();
                join
                repeat (20) @(posedge CLK2);            // a duplicated level would show up here
                if (got_lvl.size() == 0) begin
                        $display("TEST OK");
                        $finish;
                end else begin
                        $display("%0d levels arrived after the last expected one", got_lvl.size());
                        $display("TEST FAILED");
                        $fatal(1, "extra levels on the output");
                end
        end

endmodule

`default_nettype wire

/* verification/h264_chroma_dc_sva.sv */
// bound into every h264_chroma_dc instance, assumes four levels per block
`default_nettype none
`timescale 1ns/1ps

module h264_chroma_dc_sva (
        input wire                         CLK2,
        input wire                         RESET,
        input wire                         level_valid,
        input wire                         level_ready,
        input wire h264_dc_pkg::dc_level_t level,
        input wire                         level_last
);
        logic [1:0] xfer_cnt;                           // transfers within the current block

        always_ff @(posedge CLK2) begin
                if (RESET)
                        xfer_cnt <= 2'd0;
                else if (level_valid && level_ready)
                        xfer_cnt <= xfer_cnt + 2'd1;    // wraps after the 4th
        end

        // output stays quiet through reset
        a_reset_quiet: assert property (@(posedge CLK2) RESET |=> !level_valid)
                else $error("level_valid high after a reset cycle");

        a_stall_hold: assert property (@(posedge CLK2) disable iff (RESET)
                level_valid && !level_ready |=> level_valid && $stable(level))
                else $error("level dropped or changed while stalled");

        a_last_4th: assert property (@(posedge CLK2) disable iff (RESET)
                level_valid && level_ready |-> level_last == (xfer_cnt == 2'd3))
                else $error("level_last not on the 4th transfer of a block");

endmodule

bind h264_chroma_dc h264_chroma_dc_sva i_sva (
        .CLK2        (CLK2),
        .RESET       (RESET),
        .level_valid (level_valid),
        .level_ready (level_ready),
        .level       (level),
        .level_last  (level_last)
);

`default_nettype wire

/* design/h264_chroma_dc.sv */
// one chroma component stream, four dc coefs per block in raster order, levels leave in the same order
`default_nettype none
`timescale 1ns/1ps

module h264_chroma_dc #(
        parameter int QP_DEPTH = 2                      // blocks in flight
) (
        input  wire                         CLK2,
        input  wire                         RESET,
        input  wire                         coef_valid,
        input  wire  h264_dc_pkg::dc_coef_t coef,
        input  wire  h264_dc_pkg::qp_t      qp,         // taken with the 1st coef of a block
        input  wire                         level_ready,
        output logic                        coef_ready,
        output logic                        level_valid,
        output h264_dc_pkg::dc_level_t      level,
        output logic                        level_comp,
        output logic                        level_last
);
        import h264_dc_pkg::*;

        logic     dct_readyi;                           // transform can take input
        logic     dct_enable;
        logic     dct_valid;
        dc_coef_t dct_coef;                             // transformed value
        logic     quant_ready;
        qp_t      block_qp;

        h264_dc_ctrl #(
                .QP_DEPTH         (QP_DEPTH)
        ) i_ctrl (
                .CLK2             (CLK2),
                .RESET            (RESET),
                .coef_valid       (coef_valid),
                .qp               (qp),
                .transform_readyi (dct_readyi),
                .level_valid      (level_valid),
                .level_ready      (level_ready),
                .coef_ready       (coef_ready),
                .transform_enable (dct_enable),
                .block_qp         (block_qp),
                .level_comp       (level_comp),
                .level_last       (level_last)
        );

        h264dctransform #(
                .TOGETHER (0)                           // quantiser stalls per value
        ) i_dct (
                .CLK2   (CLK2),
                .RESET  (RESET),
                .READYI (dct_readyi),
                .ENABLE (dct_enable),
                .XXIN   (coef),
                .VALID  (dct_valid),
                .YYOUT  (dct_coef),
                .READYO (quant_ready)
        );

        h264_dc_quantise i_quant (
                .CLK2        (CLK2),
                .RESET       (RESET),
                .in_valid    (dct_valid),
                .in_coef     (dct_coef),
                .block_qp    (block_qp),
                .level_ready (level_ready),
                .in_ready    (quant_ready),
                .level_valid (level_valid),
                .level       (level)
        );

endmodule

`default_nettype wire

/* design/h264_dc_ctrl.sv */
// qp queue of QP_DEPTH blocks, input stalls only at a block start when full, Cb first after reset
`default_nettype none
`timescale 1ns/1ps

module h264_dc_ctrl #(
        parameter int QP_DEPTH = 2                      // blocks in flight, 1 or more
) (
        input  wire                    CLK2,
        input  wire                    RESET,
        input  wire                    coef_valid,
        input  wire  h264_dc_pkg::qp_t qp,              // sampled with 1st coef of a block
        input  wire                    transform_readyi,
        input  wire                    level_valid,
        input  wire                    level_ready,
        output logic                   coef_ready,
        output logic                   transform_enable,
        output h264_dc_pkg::qp_t       block_qp,
        output logic                   level_comp,      // 0 Cb, 1 Cr
        output logic                   level_last
);
        import h264_dc_pkg::*;

        localparam int PTR_W = (QP_DEPTH > 1) ? $clog2(QP_DEPTH) : 1;
        localparam int CNT_W = $clog2(QP_DEPTH + 1);

        qp_t              qp_q [QP_DEPTH];              // qp per block, in input order
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] rd_next;
        logic [CNT_W-1:0] q_cnt;
        logic [1:0]       coef_cnt;                     // accepted coefs in current block
        logic [1:0]       lvl_cnt;                      // sent levels in current block
        logic             q_full;
        logic             push;
        logic             pop;

        function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
                if (p == PTR_W'(QP_DEPTH - 1))
                        return '0;
                return PTR_W'(p + 1'b1);
        endfunction

        assign q_full           = q_cnt == CNT_W'(QP_DEPTH);
        // mid-block stall would deadlock at depth 1, so gate only the 1st coef
        assign coef_ready       = transform_readyi && !(q_full && coef_cnt == 2'd0);
        assign transform_enable = coef_valid && coef_ready;
        assign push             = transform_enable && coef_cnt == 2'd0;
        assign level_last       = lvl_cnt == 2'd3;
        assign pop              = level_valid && level_ready && level_last;
        assign rd_next          = ptr_inc(rd_ptr);
        // look ahead on pop so the next block's 1st value loads with its own qp
        assign block_qp         = pop ? qp_q[rd_next] : qp_q[rd_ptr];

        always_ff @(posedge CLK2) begin
                if (RESET) begin
                        wr_ptr     <= '0;
                        rd_ptr     <= '0;
                        q_cnt      <= '0;
                        coef_cnt   <= 2'd0;
                        lvl_cnt    <= 2'd0;
                        level_comp <= COMP_CB;
                end else begin
                        if (transform_enable)
                                coef_cnt <= coef_cnt + 2'd1;
                        if (level_valid && level_ready)
                                lvl_cnt <= lvl_cnt + 2'd1;      // wraps after the 4th
                        if (push)
                                wr_ptr <= ptr_inc(wr_ptr);
                        if (pop) begin
                                rd_ptr     <= rd_next;
                                level_comp <= !level_comp;      // Cb, Cr, Cb ...
                        end
                        if (push && !pop)
                                q_cnt <= q_cnt + 1'b1;
                        else if (pop && !push)
                                q_cnt <= q_cnt - 1'b1;
                end
        end

        always_ff @(posedge CLK2) begin
                if (push)
                        qp_q[wr_ptr] <= qp;             // queue storage, no reset
        end

endmodule

`default_nettype wire

/* design/h264_dc_quantise.sv */
// intra rounding only, block_qp must belong to the value entering stage two, qp above 51 not handled
`default_nettype none
`timescale 1ns/1ps

module h264_dc_quantise (
        input  wire                         CLK2,
        input  wire                         RESET,
        input  wire                         in_valid,    // pulse per value, follows in_ready by a cycle
        input  wire  h264_dc_pkg::dc_coef_t in_coef,
        input  wire  h264_dc_pkg::qp_t      block_qp,    // qp of the value moving into stage two
        input  wire                         level_ready,
        output logic                        in_ready,
        output logic                        level_valid,
        output h264_dc_pkg::dc_level_t      level
);
        import h264_dc_pkg::*;

        logic        skid_v;                            // value parked while stage one is blocked
        dc_coef_t    skid_coef;
        dc_coef_t    src_coef;                          // skid first, keeps order
        logic        s1_v;
        logic [15:0] s1_abs;                            // magnitude, 32768 still fits unsigned
        logic        s1_neg;
        logic        adv2;                              // output register free or taken
        logic        s1_take;                           // stage one may load
        logic [3:0]  qp_div;                            // qp / 6
        logic [2:0]  qp_mod;                            // qp mod 6
        logic [4:0]  qbits;                             // 15..23
        logic [5:0]  f_shr;
        qmul_t       qmul;
        logic [31:0] round2;                            // twice the rounding offset
        logic [31:0] prod;
        logic [15:0] mag;

        function automatic logic [3:0] div6(input qp_t q);
                logic [3:0] d;
                d = 4'd0;
                for (int i = 1; i <= 8; i++) begin
                        if (q >= qp_t'(6 * i))
                                d = 4'(i);
                end
                return d;
        endfunction

        assign adv2     = !level_valid || level_ready;
        assign s1_take  = !s1_v || adv2;
        // ready goes low one cycle early since the transform answers a cycle late
        assign in_ready = !(skid_v || (in_valid && !s1_take));
        assign src_coef = skid_v ? skid_coef : in_coef;

        assign qp_div = div6(block_qp);
        assign qp_mod = 3'(block_qp - qp_t'(6 * qp_div));
        assign qbits  = 5'(QBITS_BASE) + 5'(qp_div);
        assign qmul   = QMUL_TABLE[qp_mod];
        // floor(2^qbits / 3) is the top qbits bits of 0x5555_5555
        assign f_shr  = 6'd32 - 6'(qbits);
        assign round2 = (32'h5555_5555 >> f_shr) << 1;
        assign prod   = 32'(s1_abs) * 32'(qmul) + round2;
        assign mag    = 16'(prod >> (qbits + 5'd1));

        always_ff @(posedge CLK2) begin
                if (RESET) begin
                        skid_v      <= 1'b0;
                        s1_v        <= 1'b0;
                        level_valid <= 1'b0;
                end else begin
                        if (s1_take) begin
                                s1_v   <= skid_v || in_valid;
                                skid_v <= skid_v && in_valid;   // only if ready was ignored
                        end else if (in_valid) begin
                                skid_v <= 1'b1;         // stage one busy, park it
                        end
                        if (adv2)
                                level_valid <= s1_v;
                end
        end

        always_ff @(posedge CLK2) begin
                if (in_valid && !skid_v)
                        skid_coef <= in_coef;
                if (s1_take) begin                      // stage one, sign and magnitude
                        s1_abs <= src_coef[15] ? 16'(-src_coef) : 16'(src_coef);
                        s1_neg <= src_coef[15];
                end
                if (adv2)                               // stage two, scale, round, shift, sign
                        level <= s1_neg ? dc_level_t'(16'd0 - mag) : dc_level_t'(mag);
        end

endmodule

`default_nettype wire

/* design/h264dctransform.sv */
// forward 2x2 hadamard only, raster order in and out, one block in flight, sums wrap at 16 bits
`default_nettype none
`timescale 1ns/1ps

module h264dctransform #(
        parameter int TOGETHER = 0                      // 1 keeps the four outputs back to back
) (
        input  wire                        CLK2,        // fast clock
        input  wire                        RESET,       // sync, active high
        output logic                       READYI,      // high when ENABLE may be given
        input  wire                        ENABLE,      // one input value per high cycle
        input  wire  h264_dc_pkg::dc_coef_t XXIN,       // input values in raster order
        output logic                       VALID,       // one output value per high cycle
        output h264_dc_pkg::dc_coef_t      YYOUT,       // output values in raster order
        input  wire                        READYO       // downstream may take a value next cycle
);
        import h264_dc_pkg::*;

        dc_coef_t    xxii;                              // registered input value
        logic        enablei;                           // registered ENABLE
        dc_coef_t    xx00;                              // row 0 sum after 2nd value
        dc_coef_t    xx01;                              // row 0 difference
        dc_coef_t    xx10;                              // row 1 sum after 4th value
        dc_coef_t    xx11;                              // row 1 difference
        logic [1:0]  ixx;                               // position, shared by input and output phase
        logic        iout;                              // block complete, output phase running
        logic        in_step;
        logic        out_step;

        // input side is closed as soon as the 4th value sits in the register stage
        assign READYI   = !(iout || (enablei && ixx == 2'd3));

        assign in_step  = enablei;
        assign out_step = iout && (READYO || (TOGETHER == 1 && ixx != 2'd0));

        // control state
        always_ff @(posedge CLK2) begin
                if (RESET) begin
                        enablei <= 1'b0;
                        ixx     <= 2'd0;
                        iout    <= 1'b0;
                        VALID   <= 1'b0;
                end else begin
                        enablei <= ENABLE;
                        if (in_step || out_step)
                                ixx <= ixx + 2'd1;      // phases never overlap
                        if (in_step && ixx == 2'd3)
                                iout <= 1'b1;           // last row done
                        else if (out_step && ixx == 2'd3)
                                iout <= 1'b0;           // last column value sent
                        VALID   <= out_step;
                end
        end

        // datapath, no reset on values
        always_ff @(posedge CLK2) begin
                xxii <= XXIN;
                if (in_step) begin
                        case (ixx)
                                2'd0: xx00 <= xxii;
                                2'd1: begin
                                        xx00 <= xx00 + xxii;    // row 0 sum
                                        xx01 <= xx00 - xxii;    // row 0 difference
                                end
                                2'd2: xx10 <= xxii;
                                default: begin
                                        xx10 <= xx10 + xxii;
                                        xx11 <= xx10 - xxii;
                                end
                        endcase
                end
                if (out_step) begin
                        case (ixx)                      // column stage, raster order out
                                2'd0: YYOUT <= xx00 + xx10;
                                2'd1: YYOUT <= xx01 + xx11;
                                2'd2: YYOUT <= xx00 - xx10;
                                default: YYOUT <= xx01 - xx11;
                        endcase
                end
        end

endmodule

`default_nettype wire

/* design/h264_dc_pkg.sv */
// types and multiplier table for the chroma dc path, qp is only meaningful from 0 to 51
`default_nettype none

package h264_dc_pkg;

        // transform input and output, wraps at 16 bits like the hadamard itself
        typedef logic signed [15:0] dc_coef_t;

        // quantised level, magnitude stays below 2^14 for any 16-bit input
        typedef logic signed [15:0] dc_level_t;

        typedef logic [5:0] qp_t;                       // 0..51, values above are not checked
        typedef logic [13:0] qmul_t;                    // largest entry 13107 needs 14 bits

        // base of the quantiser shift, qbits = QBITS_BASE + qp / 6
        localparam int QBITS_BASE = 15;

        // position 0 forward multipliers, indexed by qp mod 6
        localparam qmul_t QMUL_TABLE [0:5] = '{
                14'd13107,                              // qp mod 6 = 0
                14'd11916,
                14'd10082,
                14'd9362,
                14'd8192,
                14'd7282                                // qp mod 6 = 5
        };

        // level_comp encoding
        localparam logic COMP_CB = 1'b0;
        localparam logic COMP_CR = 1'b1;

endpackage

`default_nettype wire
